// File: verilog/cbus_params.svh
`ifndef CBUS_PARAMS_SVH
`define CBUS_PARAMS_SVH

// cache geometry
`define CBUS_SETS 32
`define CBUS_WAYS 2

// bus widths
`define CBUS_WORD_W 64
`define CBUS_ADDR_W 64

// addresses with this bit clear go straight to memory
`define CBUS_UNCACHED_BIT 31

// address split: tag | index | 3-bit byte offset
`define CBUS_INDEX_W 5
`define CBUS_TAG_W 56

`endif

// File: verilog/cbus_pkg.sv
`include "cbus_params.svh"

package cbus_pkg;

    typedef logic [`CBUS_ADDR_W-1:0] addr_t;
    typedef logic [`CBUS_WORD_W-1:0] word_t;

    // one enable bit per byte lane
    typedef logic [`CBUS_WORD_W/8-1:0] strobe_t;

    // address bits 7..3
    typedef logic [`CBUS_INDEX_W-1:0] set_index_t;

    // address bits 63..8
    typedef logic [`CBUS_TAG_W-1:0] tag_t;

    typedef logic [$clog2(`CBUS_WAYS)-1:0] way_t;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_evict,
        st_install,
        st_respond,
        st_bypass,
        st_done
    } ctrl_state_t;

endpackage

// File: verilog/lru_table.sv
`timescale 1ns/1ps
`include "cbus_params.svh"

module lru_table (
    input  logic                  clk,
    input  logic                  reset,
    input  cbus_pkg::addr_t       req_addr,
    input  logic                  touch,
    input  cbus_pkg::way_t        sel_way,
    input  logic [`CBUS_WAYS-1:0] set_valid,
    output cbus_pkg::way_t        victim_way
);

    // names the least recently used way of each set
    cbus_pkg::way_t       lru_q [`CBUS_SETS];
    cbus_pkg::set_index_t index;

    assign index = req_addr[`CBUS_INDEX_W+2:3];

    // lowest invalid way wins, else the lru way
    always_comb begin
        victim_way = lru_q[index];
        for (int w = `CBUS_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                victim_way = cbus_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < `CBUS_SETS; s++) begin
                lru_q[s] <= '0;
            end
        end else if (touch) begin
            // two ways, so the other one becomes lru
            lru_q[index] <= ~sel_way;
        end
    end

endmodule

// File: verilog/cache_array.sv
`timescale 1ns/1ps
`include "cbus_params.svh"

module cache_array (
    input  logic                   clk,
    input  logic                   reset,
    input  cbus_pkg::addr_t        req_addr,
    input  cbus_pkg::strobe_t      req_strobe,
    input  cbus_pkg::word_t        req_data,
    input  logic                   req_is_write,
    input  logic                   hit_write,
    input  logic                   capture_fill,
    input  logic                   install,
    input  cbus_pkg::way_t         sel_way,
    input  cbus_pkg::word_t        mem_rdata,
    output logic                   hit,
    output cbus_pkg::way_t         hit_way,
    output cbus_pkg::word_t        hit_data,
    output logic                   victim_dirty,
    output cbus_pkg::tag_t         victim_tag,
    output cbus_pkg::word_t        victim_data,
    output cbus_pkg::word_t        fill_data,
    output logic [`CBUS_WAYS-1:0]  set_valid
);

    logic [`CBUS_WAYS-1:0] valid_q [`CBUS_SETS];
    logic [`CBUS_WAYS-1:0] dirty_q [`CBUS_SETS];
    cbus_pkg::tag_t        tag_q   [`CBUS_SETS][`CBUS_WAYS];
    cbus_pkg::word_t       data_q  [`CBUS_SETS][`CBUS_WAYS];

    // fetched word, kept across a write-back
    cbus_pkg::word_t       fill_q;

    cbus_pkg::set_index_t  index;
    cbus_pkg::tag_t        req_tag;
    cbus_pkg::word_t       byte_mask;
    cbus_pkg::word_t       hit_merged;
    cbus_pkg::word_t       fill_merged;
    logic [`CBUS_WAYS-1:0] way_match;

    function automatic cbus_pkg::word_t merge_bytes(
        input cbus_pkg::word_t old_word,
        input cbus_pkg::word_t new_word,
        input cbus_pkg::word_t mask
    );
        return (new_word & mask) | (old_word & ~mask);
    endfunction

    assign index   = req_addr[`CBUS_INDEX_W+2:3];
    assign req_tag = req_addr[`CBUS_ADDR_W-1:`CBUS_ADDR_W-`CBUS_TAG_W];

    // strobe bit per lane to byte mask
    always_comb begin
        for (int b = 0; b < `CBUS_WORD_W/8; b++) begin
            byte_mask[b*8 +: 8] = {8{req_strobe[b]}};
        end
    end

    // tag compare in every way of the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CBUS_WAYS; w++) begin
            way_match[w] = valid_q[index][w] && (tag_q[index][w] == req_tag);
            if (way_match[w]) begin
                hit_way = cbus_pkg::way_t'(w);
            end
        end
    end

    assign hit       = |way_match;
    assign hit_data  = data_q[index][hit_way];
    assign set_valid = valid_q[index];

    assign victim_dirty = valid_q[index][sel_way] && dirty_q[index][sel_way];
    assign victim_tag   = tag_q[index][sel_way];
    assign victim_data  = data_q[index][sel_way];
    assign fill_data    = fill_q;

    assign hit_merged  = merge_bytes(hit_data, req_data, byte_mask);
    assign fill_merged = req_is_write ? merge_bytes(fill_q, req_data, byte_mask) : fill_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < `CBUS_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (hit_write) begin
            dirty_q[index][sel_way] <= 1'b1;
        end else if (install) begin
            valid_q[index][sel_way] <= 1'b1;
            dirty_q[index][sel_way] <= req_is_write;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_write) begin
            data_q[index][sel_way] <= hit_merged;
        end else if (install) begin
            tag_q[index][sel_way]  <= req_tag;
            data_q[index][sel_way] <= fill_merged;
        end
        // after install the buffer holds the word returned to the processor
        if (capture_fill) begin
            fill_q <= mem_rdata;
        end else if (install) begin
            fill_q <= fill_merged;
        end
    end

endmodule

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ps
`include "cbus_params.svh"

module cache_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  logic                req_is_write,
    input  cbus_pkg::addr_t     req_addr,
    input  cbus_pkg::strobe_t   req_strobe,
    input  cbus_pkg::word_t     req_data,
    input  logic                mem_ready,
    input  logic                mem_last,
    input  cbus_pkg::word_t     mem_rdata,
    input  logic                hit,
    input  cbus_pkg::way_t      hit_way,
    input  cbus_pkg::word_t     hit_data,
    input  logic                victim_dirty,
    input  cbus_pkg::tag_t      victim_tag,
    input  cbus_pkg::word_t     victim_data,
    input  cbus_pkg::way_t      victim_way,
    input  cbus_pkg::word_t     fill_data,
    output logic                resp_ready,
    output logic                resp_last,
    output cbus_pkg::word_t     resp_data,
    output logic                mem_valid,
    output logic                mem_is_write,
    output cbus_pkg::addr_t     mem_addr,
    output cbus_pkg::strobe_t   mem_strobe,
    output cbus_pkg::word_t     mem_wdata,
    output logic                hit_write,
    output logic                capture_fill,
    output logic                install,
    output cbus_pkg::way_t      sel_way,
    output logic                touch
);

    cbus_pkg::ctrl_state_t state;
    cbus_pkg::set_index_t  index;
    cbus_pkg::tag_t        req_tag;
    logic                  cached;
    logic                  take;
    logic                  cached_hit;
    logic                  mem_done;

    assign index   = req_addr[`CBUS_INDEX_W+2:3];
    assign req_tag = req_addr[`CBUS_ADDR_W-1:`CBUS_ADDR_W-`CBUS_TAG_W];
    assign cached  = req_addr[`CBUS_UNCACHED_BIT];

    // request accepted only from idle
    assign take       = (state == cbus_pkg::st_idle) && req_valid;
    assign cached_hit = take && cached && hit;
    assign mem_done   = mem_ready && mem_last;

    // array and recency strobes
    assign hit_write    = cached_hit && req_is_write;
    assign capture_fill = (state == cbus_pkg::st_fetch) && mem_done;
    assign install      = (state == cbus_pkg::st_install);
    assign touch        = cached_hit || install;

    // hit way during lookup, replacement way for the rest of a miss
    assign sel_way = (state == cbus_pkg::st_idle) ? hit_way : victim_way;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= cbus_pkg::st_idle;
            resp_ready   <= 1'b0;
            resp_last    <= 1'b0;
            mem_valid    <= 1'b0;
            mem_is_write <= 1'b0;
        end else begin
            case (state)
                cbus_pkg::st_idle: begin
                    if (req_valid) begin
                        if (!cached) begin
                            mem_valid    <= 1'b1;
                            mem_is_write <= req_is_write;
                            state        <= cbus_pkg::st_bypass;
                        end else if (hit) begin
                            resp_ready <= 1'b1;
                            resp_last  <= 1'b1;
                            state      <= cbus_pkg::st_done;
                        end else begin
                            mem_valid    <= 1'b1;
                            mem_is_write <= 1'b0;
                            state        <= cbus_pkg::st_fetch;
                        end
                    end
                end
                cbus_pkg::st_fetch: begin
                    if (mem_done) begin
                        mem_valid <= 1'b0;
                        // a dirty victim goes back to memory before the install
                        state <= victim_dirty ? cbus_pkg::st_evict : cbus_pkg::st_install;
                    end
                end
                cbus_pkg::st_evict: begin
                    if (!mem_valid) begin
                        mem_valid    <= 1'b1;
                        mem_is_write <= 1'b1;
                    end else if (mem_done) begin
                        mem_valid <= 1'b0;
                        state     <= cbus_pkg::st_install;
                    end
                end
                cbus_pkg::st_install: begin
                    state <= cbus_pkg::st_respond;
                end
                cbus_pkg::st_respond: begin
                    resp_ready <= 1'b1;
                    resp_last  <= 1'b1;
                    state      <= cbus_pkg::st_done;
                end
                cbus_pkg::st_bypass: begin
                    if (mem_done) begin
                        mem_valid  <= 1'b0;
                        resp_ready <= 1'b1;
                        resp_last  <= 1'b1;
                        state      <= cbus_pkg::st_done;
                    end
                end
                default: begin
                    // response pulse ends here, one quiet cycle before idle
                    resp_ready <= 1'b0;
                    resp_last  <= 1'b0;
                    state      <= cbus_pkg::st_idle;
                end
            endcase
        end
    end

    // bus payload
    always_ff @(posedge clk) begin
        case (state)
            cbus_pkg::st_idle: begin
                if (req_valid && !cached) begin
                    mem_addr   <= req_addr;
                    mem_strobe <= req_strobe;
                    mem_wdata  <= req_data;
                end else if (req_valid) begin
                    mem_addr   <= {req_tag, index, 3'b000};
                    mem_strobe <= '1;
                    resp_data  <= hit_data;
                end
            end
            cbus_pkg::st_fetch: begin
                if (mem_done && victim_dirty) begin
                    mem_addr   <= {victim_tag, index, 3'b000};
                    mem_strobe <= '1;
                    mem_wdata  <= victim_data;
                end
            end
            cbus_pkg::st_respond: begin
                resp_data <= fill_data;
            end
            cbus_pkg::st_bypass: begin
                if (mem_done) begin
                    resp_data <= mem_rdata;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: verilog/cached_cbus.sv
`timescale 1ns/1ps
`include "cbus_params.svh"

module cached_cbus (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  logic               req_is_write,
    input  cbus_pkg::addr_t    req_addr,
    input  cbus_pkg::strobe_t  req_strobe,
    input  cbus_pkg::word_t    req_data,
    output logic               resp_ready,
    output logic               resp_last,
    output cbus_pkg::word_t    resp_data,
    output logic               mem_valid,
    output logic               mem_is_write,
    output cbus_pkg::addr_t    mem_addr,
    output cbus_pkg::strobe_t  mem_strobe,
    output cbus_pkg::word_t    mem_wdata,
    input  logic               mem_ready,
    input  logic               mem_last,
    input  cbus_pkg::word_t    mem_rdata
);

    logic                  hit;
    cbus_pkg::way_t        hit_way;
    cbus_pkg::word_t       hit_data;
    logic                  victim_dirty;
    cbus_pkg::tag_t        victim_tag;
    cbus_pkg::word_t       victim_data;
    cbus_pkg::way_t        victim_way;
    cbus_pkg::word_t       fill_data;
    logic                  hit_write;
    logic                  capture_fill;
    logic                  install;
    cbus_pkg::way_t        sel_way;
    logic                  touch;
    logic [`CBUS_WAYS-1:0] set_valid;

    cache_ctrl i_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_is_write (req_is_write),
        .req_addr     (req_addr),
        .req_strobe   (req_strobe),
        .req_data     (req_data),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_data     (hit_data),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (victim_data),
        .victim_way   (victim_way),
        .fill_data    (fill_data),
        .resp_ready   (resp_ready),
        .resp_last    (resp_last),
        .resp_data    (resp_data),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_strobe   (mem_strobe),
        .mem_wdata    (mem_wdata),
        .hit_write    (hit_write),
        .capture_fill (capture_fill),
        .install      (install),
        .sel_way      (sel_way),
        .touch        (touch)
    );

    cache_array i_array (
        .clk          (clk),
        .reset        (reset),
        .req_addr     (req_addr),
        .req_strobe   (req_strobe),
        .req_data     (req_data),
        .req_is_write (req_is_write),
        .hit_write    (hit_write),
        .capture_fill (capture_fill),
        .install      (install),
        .sel_way      (sel_way),
        .mem_rdata    (mem_rdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_data     (hit_data),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (victim_data),
        .fill_data    (fill_data),
        .set_valid    (set_valid)
    );

    lru_table i_lru (
        .clk        (clk),
        .reset      (reset),
        .req_addr   (req_addr),
        .touch      (touch),
        .sel_way    (sel_way),
        .set_valid  (set_valid),
        .victim_way (victim_way)
    );

endmodule

// File: tb/tb_cached_cbus.sv
`timescale 1ns/1ps

module tb_cached_cbus;

    // about 25 requests of under 20 cycles each, with wide margin
    localparam int max_cycles = 3000;

    logic                clk;
    logic                reset;
    logic                req_valid;
    logic                req_is_write;
    cbus_pkg::addr_t     req_addr;
    cbus_pkg::strobe_t   req_strobe;
    cbus_pkg::word_t     req_data;
    logic                resp_ready;
    logic                resp_last;
    cbus_pkg::word_t     resp_data;
    logic                mem_valid;
    logic                mem_is_write;
    cbus_pkg::addr_t     mem_addr;
    cbus_pkg::strobe_t   mem_strobe;
    cbus_pkg::word_t     mem_wdata;
    logic                mem_ready;
    logic                mem_last;
    cbus_pkg::word_t     mem_rdata;

    // memory model contents and the processor's expected view, keyed by address / 8
    cbus_pkg::word_t     mem_words [cbus_pkg::addr_t];
    cbus_pkg::word_t     shadow [cbus_pkg::addr_t];

    // one entry per memory request
    cbus_pkg::addr_t     log_addr [$];
    bit                  log_write [$];
    cbus_pkg::strobe_t   log_strobe [$];
    cbus_pkg::word_t     log_wdata [$];

    int                  seed = 55;
    int                  cycle_count;
    int                  test_count;
    int                  failed_tests;
    int                  error_count;
    int                  test_errors;
    string               test_name;

    cached_cbus i_cached_cbus (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_is_write (req_is_write),
        .req_addr     (req_addr),
        .req_strobe   (req_strobe),
        .req_data     (req_data),
        .resp_ready   (resp_ready),
        .resp_last    (resp_last),
        .resp_data    (resp_data),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_strobe   (mem_strobe),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // untouched memory, a function of the full word address
    function automatic cbus_pkg::word_t fill_pattern(input cbus_pkg::addr_t addr);
        return {addr[31:0], addr[63:32]} ^ 64'h9e37_79b9_7f4a_7c15;
    endfunction

    function automatic cbus_pkg::word_t merge_lanes(
        input cbus_pkg::word_t   old_word,
        input cbus_pkg::word_t   new_word,
        input cbus_pkg::strobe_t strobe
    );
        cbus_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < 8; b++) begin
            if (strobe[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic cbus_pkg::word_t stored_word(input cbus_pkg::addr_t addr);
        cbus_pkg::addr_t key;
        key = addr >> 3;
        if (mem_words.exists(key)) begin
            return mem_words[key];
        end
        return fill_pattern({addr[63:3], 3'b000});
    endfunction

    function automatic cbus_pkg::word_t expected_word(input cbus_pkg::addr_t addr);
        cbus_pkg::addr_t key;
        key = addr >> 3;
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return fill_pattern({addr[63:3], 3'b000});
    endfunction

    // cached region has bit 31 set, index in bits 7..3, tag from bit 8
    function automatic cbus_pkg::addr_t line_addr(input int tag, input int set);
        return 64'h0000_0000_8000_0000 | (cbus_pkg::addr_t'(tag) << 8)
            | (cbus_pkg::addr_t'(set) << 3);
    endfunction

    // memory answers 2 or 3 cycles after it sees mem_valid
    initial begin
        int latency;
        mem_ready = 1'b0;
        mem_last = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_ready = 1'b0;
            mem_last = 1'b0;
            if (mem_valid) begin
                latency = ($random(seed) & 1) + 2;
                log_addr.push_back(mem_addr);
                log_write.push_back(mem_is_write);
                log_strobe.push_back(mem_strobe);
                log_wdata.push_back(mem_wdata);
                repeat (latency) @(posedge clk);
                #1;
                if (mem_is_write) begin
                    mem_words[mem_addr >> 3] =
                        merge_lanes(stored_word(mem_addr), mem_wdata, mem_strobe);
                end else begin
                    mem_rdata = stored_word(mem_addr);
                end
                mem_ready = 1'b1;
                mem_last = 1'b1;
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check_word(
        input string           label,
        input cbus_pkg::word_t expected,
        input cbus_pkg::word_t actual
    );
        if (actual !== expected) begin
            $display("error: %s, %s: expected %h, actual %h", test_name, label, expected,
                actual);
            test_errors++;
        end
    endtask

    task automatic check_addr(
        input string           label,
        input cbus_pkg::addr_t expected,
        input cbus_pkg::addr_t actual
    );
        if (actual !== expected) begin
            $display("error: %s, %s: expected %h, actual %h", test_name, label, expected,
                actual);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string label, input bit expected, input bit actual);
        if (actual != expected) begin
            $display("error: %s, %s: expected %0b, actual %0b", test_name, label, expected,
                actual);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        test_count++;
        error_count += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    // holds the request until the response pulse, then one idle cycle
    task automatic bus_request(
        input  bit                is_write,
        input  cbus_pkg::addr_t   addr,
        input  cbus_pkg::strobe_t strobe,
        input  cbus_pkg::word_t   data,
        output cbus_pkg::word_t   rdata,
        output int                cycles
    );
        cycles = 0;
        req_valid = 1'b1;
        req_is_write = is_write;
        req_addr = addr;
        req_strobe = strobe;
        req_data = data;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!resp_ready);
        rdata = resp_data;
        check_bit("resp_last with resp_ready", 1'b1, resp_last);
        req_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic read_expect(input cbus_pkg::addr_t addr, input string label,
        output int cycles);
        cbus_pkg::word_t rdata;
        bus_request(1'b0, addr, '1, '0, rdata, cycles);
        check_word(label, expected_word(addr), rdata);
    endtask

    task automatic write_word(
        input  cbus_pkg::addr_t   addr,
        input  cbus_pkg::strobe_t strobe,
        input  cbus_pkg::word_t   data,
        output int                cycles
    );
        cbus_pkg::word_t resp_word;
        bus_request(1'b1, addr, strobe, data, resp_word, cycles);
        shadow[addr >> 3] = merge_lanes(expected_word(addr), data, strobe);
    endtask

    task automatic reset_defaults();
        cbus_pkg::addr_t addr;
        int first;
        int cycles;
        start_test("reset");
        check_bit("resp_ready low", 1'b0, resp_ready);
        check_bit("mem_valid low", 1'b0, mem_valid);
        addr = line_addr(0, 1);
        first = log_addr.size();
        read_expect(addr, "first cached read", cycles);
        check_bit("one memory request", 1'b1, log_addr.size() == first + 1);
        check_addr("read address", addr, log_addr[first]);
        check_bit("request is a read", 1'b0, log_write[first]);
        finish_test();
    endtask

    task automatic uncached_access();
        cbus_pkg::addr_t addr;
        int first;
        int cycles;
        start_test("uncached");
        addr = 64'h0000_0000_0000_1238;
        first = log_addr.size();
        read_expect(addr, "first read", cycles);
        read_expect(addr, "second read", cycles);
        check_bit("both reads reach memory", 1'b1, log_addr.size() == first + 2);
        check_addr("first read address", addr, log_addr[first]);
        check_addr("second read address", addr, log_addr[first + 1]);
        write_word(addr, 8'h3c, 64'h0123_4567_89ab_cdef, cycles);
        check_bit("write forwarded", 1'b1, log_write[first + 2]);
        check_addr("write address", addr, log_addr[first + 2]);
        check_word("write data", 64'h0123_4567_89ab_cdef, log_wdata[first + 2]);
        check_bit("write strobe unchanged", 1'b1, log_strobe[first + 2] == 8'h3c);
        read_expect(addr, "read after write", cycles);
        finish_test();
    endtask

    task automatic fill_then_hit();
        cbus_pkg::addr_t addr;
        int first;
        int cycles;
        start_test("fill then hit");
        addr = line_addr(0, 2);
        first = log_addr.size();
        read_expect(addr, "miss read", cycles);
        check_bit("miss goes to memory", 1'b1, log_addr.size() == first + 1);
        read_expect(addr, "hit read", cycles);
        check_bit("hit stays off the bus", 1'b1, log_addr.size() == first + 1);
        check_bit("hit latency one cycle", 1'b1, cycles == 1);
        finish_test();
    endtask

    task automatic write_hit_merge();
        cbus_pkg::addr_t addr;
        int first;
        int cycles;
        start_test("write hit");
        addr = line_addr(0, 3);
        read_expect(addr, "fill", cycles);
        first = log_addr.size();
        write_word(addr, 8'b1010_0101, 64'hfeed_face_cafe_f00d, cycles);
        check_bit("write hit latency one cycle", 1'b1, cycles == 1);
        read_expect(addr, "read back", cycles);
        check_bit("no memory access", 1'b1, log_addr.size() == first);
        finish_test();
    endtask

    task automatic dirty_eviction();
        cbus_pkg::addr_t a;
        cbus_pkg::addr_t b;
        cbus_pkg::addr_t c;
        int first;
        int cycles;
        start_test("dirty eviction");
        a = line_addr(1, 5);
        b = line_addr(2, 5);
        c = line_addr(3, 5);
        read_expect(a, "fill first", cycles);
        read_expect(b, "fill second", cycles);
        write_word(a, 8'h0f, 64'h1111_2222_3333_4444, cycles);
        // first line becomes least recently used
        read_expect(b, "touch second", cycles);
        first = log_addr.size();
        read_expect(c, "third tag", cycles);
        check_bit("read then write-back", 1'b1, log_addr.size() == first + 2);
        check_addr("fetch address", c, log_addr[first]);
        check_bit("fetch is a read", 1'b0, log_write[first]);
        check_addr("write-back address", a, log_addr[first + 1]);
        check_bit("write-back is a write", 1'b1, log_write[first + 1]);
        check_word("write-back data", expected_word(a), log_wdata[first + 1]);
        read_expect(b, "re-read second", cycles);
        read_expect(a, "re-read first", cycles);
        read_expect(c, "re-read third", cycles);
        finish_test();
    endtask

    task automatic clean_eviction();
        cbus_pkg::addr_t a;
        cbus_pkg::addr_t b;
        cbus_pkg::addr_t c;
        int first;
        int cycles;
        start_test("clean eviction");
        a = line_addr(1, 9);
        b = line_addr(2, 9);
        c = line_addr(3, 9);
        read_expect(a, "fill first", cycles);
        read_expect(b, "fill second", cycles);
        read_expect(a, "touch first", cycles);
        read_expect(b, "touch second", cycles);
        first = log_addr.size();
        read_expect(c, "third tag", cycles);
        check_bit("single memory request", 1'b1, log_addr.size() == first + 1);
        check_bit("no write-back", 1'b0, log_write[first]);
        first = log_addr.size();
        read_expect(a, "re-fetch first", cycles);
        check_bit("evicted line fetched again", 1'b1, log_addr.size() == first + 1);
        read_expect(c, "re-read third", cycles);
        finish_test();
    endtask

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        req_is_write = 1'b0;
        req_addr = '0;
        req_strobe = '0;
        req_data = '0;
        test_count = 0;
        failed_tests = 0;
        error_count = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_defaults();
        uncached_access();
        fill_then_hit();
        write_hit_merge();
        dirty_eviction();
        clean_eviction();
        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+verilog
verilog/cbus_pkg.sv
verilog/lru_table.sv
verilog/cache_array.sv
verilog/cache_ctrl.sv
verilog/cached_cbus.sv
tb/tb_cached_cbus.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
    --top-module tb_cached_cbus > build.log 2>&1 &&
    ./obj_dir/Vtb_cached_cbus > sim.log 2>&1 ||
    { cat build.log; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
